//--- design/fp2_add_sub.sv
`default_nettype none
`include "xadd_defs.svh"

module fp2_add_sub (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start,
  input  xadd_pkg::addsub_op_e  op,
  output xadd_pkg::mem_rd_req_t rd_a,
  output xadd_pkg::mem_rd_req_t rd_b,
  input  xadd_pkg::digit_t      dout_a,
  input  xadd_pkg::digit_t      dout_b,
  output xadd_pkg::mem_wr_req_t wr,
  output logic                  done
);
  import xadd_pkg::*;

  localparam int RADIX = `XADD_RADIX;
  localparam int DIGITS = `XADD_DIGITS;
  localparam int CNT_W = `XADD_ADDR_W - 1;
  localparam logic [RADIX*DIGITS-1:0] PRIME = `XADD_PRIME;
  localparam logic [CNT_W-1:0] LAST = CNT_W'(DIGITS - 1);

  typedef enum logic [1:0] {
    S_IDLE,
    S_READ,
    S_FOLD,
    S_WRITE
  } state_e;

  state_e           state;
  logic             half;
  logic [CNT_W-1:0] cnt;
  logic             rd_vld;
  logic [CNT_W-1:0] rd_idx;

  addsub_op_e op_q;
  logic       c_raw;
  logic       c_cor;
  digit_t     raw_buf [DIGITS];
  digit_t     cor_buf [DIGITS];

  digit_t         p_digit;
  logic           cin_raw;
  logic           cin_cor;
  logic [RADIX:0] raw_sum;
  logic [RADIX:0] cor_sum;
  logic           use_cor;

  // one digit of both chains, on data returned for rd_idx
  always_comb begin
    p_digit = PRIME[rd_idx*RADIX +: RADIX];
    cin_raw = (rd_idx == '0) ? 1'b0 : c_raw;
    cin_cor = (rd_idx == '0) ? 1'b0 : c_cor;
    if (op_q == OP_ADD) begin
      // a + b, then (a + b) - p
      raw_sum = {1'b0, dout_a} + {1'b0, dout_b} + {{RADIX{1'b0}}, cin_raw};
      cor_sum = {1'b0, raw_sum[RADIX-1:0]} - {1'b0, p_digit} - {{RADIX{1'b0}}, cin_cor};
    end else begin
      // a - b, then (a - b) + p
      raw_sum = {1'b0, dout_a} - {1'b0, dout_b} - {{RADIX{1'b0}}, cin_raw};
      cor_sum = {1'b0, raw_sum[RADIX-1:0]} + {1'b0, p_digit} + {{RADIX{1'b0}}, cin_cor};
    end
  end

  // add: sum overflowed or sum >= p; sub: a < b
  assign use_cor = (op_q == OP_ADD) ? (c_raw | ~c_cor) : c_raw;

  assign rd_a = '{en: (state == S_READ), addr: {half, cnt}};
  assign rd_b = '{en: (state == S_READ), addr: {half, cnt}};

  assign wr = '{
    en:   (state == S_WRITE),
    addr: {half, cnt},
    data: use_cor ? cor_buf[cnt] : raw_buf[cnt]
  };

  assign done = (state == S_WRITE) && half && (cnt == LAST);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state  <= S_IDLE;
      half   <= 1'b0;
      cnt    <= '0;
      rd_vld <= 1'b0;
    end else begin
      rd_vld <= (state == S_READ);
      case (state)
        S_IDLE: begin
          if (start) begin
            state <= S_READ;
            half  <= 1'b0;
            cnt   <= '0;
          end
        end
        S_READ: begin
          cnt <= (cnt == LAST) ? '0 : cnt + 1'b1;
          if (cnt == LAST) begin
            state <= S_FOLD;
          end
        end
        // last digit still folding
        S_FOLD: begin
          state <= S_WRITE;
        end
        S_WRITE: begin
          cnt <= (cnt == LAST) ? '0 : cnt + 1'b1;
          if (cnt == LAST) begin
            half  <= ~half;
            state <= half ? S_IDLE : S_READ;
          end
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start && (state == S_IDLE)) begin
      op_q <= op;
    end
    rd_idx <= cnt;
    if (rd_vld) begin
      raw_buf[rd_idx] <= raw_sum[RADIX-1:0];
      cor_buf[rd_idx] <= cor_sum[RADIX-1:0];
      c_raw           <= raw_sum[RADIX];
      c_cor           <= cor_sum[RADIX];
    end
  end

endmodule

`default_nettype wire

//--- design/fp2_word_mem.sv
`default_nettype none
`include "xadd_defs.svh"

module fp2_word_mem (
  input  logic                  clk,
  input  xadd_pkg::mem_rd_req_t rd,
  input  xadd_pkg::mem_wr_req_t wr,
  output xadd_pkg::digit_t      dout
);
  import xadd_pkg::*;

  localparam int DEPTH = 2 * `XADD_DIGITS;

  // real half in the low addresses, imag half above
  digit_t ram [DEPTH];

  // single port, write wins over a read in the same cycle
  always_ff @(posedge clk) begin
    if (wr.en) begin
      ram[wr.addr] <= wr.data;
    end else if (rd.en) begin
      dout <= ram[rd.addr];
    end
  end

endmodule

`default_nettype wire

//--- design/operand_router.sv
`default_nettype none

module operand_router (
  input  logic                  clk,
  input  logic                  rst,
  input  xadd_pkg::addsub_cmd_t cmd,
  input  logic                  busy,
  input  xadd_pkg::mem_rd_req_t rd_a,
  input  xadd_pkg::mem_rd_req_t rd_b,
  input  xadd_pkg::mem_wr_req_t wr,
  output xadd_pkg::digit_t      dout_a,
  output xadd_pkg::digit_t      dout_b,
  output xadd_pkg::mem_rd_req_t xp_rd,
  output xadd_pkg::mem_rd_req_t zp_rd,
  input  xadd_pkg::digit_t      xp_dout,
  input  xadd_pkg::digit_t      zp_dout,
  input  xadd_pkg::mem_rd_req_t t2_rd,
  input  xadd_pkg::mem_rd_req_t t3_rd,
  output xadd_pkg::digit_t      t2_dout,
  output xadd_pkg::digit_t      t3_dout
);
  import xadd_pkg::*;

  localparam mem_rd_req_t RD_IDLE = '0;

  mem_rd_req_t  t4_rd;
  mem_rd_req_t  t5_rd;
  mem_rd_req_t  t2_mem_rd;
  mem_rd_req_t  t3_mem_rd;
  mem_wr_req_t  t4_wr;
  mem_wr_req_t  t5_wr;
  mem_wr_req_t  t2_wr;
  mem_wr_req_t  t3_wr;
  digit_t       t4_dout;
  digit_t       t5_dout;
  operand_sel_e src_a_q;
  operand_sel_e src_b_q;

  // port a wins if both ports address the same memory
  function automatic mem_rd_req_t pick_rd(input operand_sel_e sel, input addsub_cmd_t c,
                                          input mem_rd_req_t a, input mem_rd_req_t b);
    mem_rd_req_t req;
    req = RD_IDLE;
    if (a.en && (c.src_a == sel)) begin
      req = a;
    end else if (b.en && (c.src_b == sel)) begin
      req = b;
    end
    return req;
  endfunction

  function automatic mem_wr_req_t pick_wr(input dest_sel_e sel, input addsub_cmd_t c,
                                          input mem_wr_req_t w);
    mem_wr_req_t req;
    req = w;
    req.en = w.en && (c.dst == sel);
    return req;
  endfunction

  function automatic digit_t pick_dout(input operand_sel_e sel, input digit_t xp,
                                       input digit_t zp, input digit_t t4, input digit_t t5);
    case (sel)
      SRC_XP:  return xp;
      SRC_ZP:  return zp;
      SRC_T4:  return t4;
      default: return t5;
    endcase
  endfunction

  assign xp_rd = pick_rd(SRC_XP, cmd, rd_a, rd_b);
  assign zp_rd = pick_rd(SRC_ZP, cmd, rd_a, rd_b);
  assign t4_rd = pick_rd(SRC_T4, cmd, rd_a, rd_b);
  assign t5_rd = pick_rd(SRC_T5, cmd, rd_a, rd_b);

  assign t4_wr = pick_wr(DST_T4, cmd, wr);
  assign t5_wr = pick_wr(DST_T5, cmd, wr);
  assign t2_wr = pick_wr(DST_T2, cmd, wr);
  assign t3_wr = pick_wr(DST_T3, cmd, wr);

  // result memories belong to the outside only while idle
  assign t2_mem_rd = busy ? RD_IDLE : t2_rd;
  assign t3_mem_rd = busy ? RD_IDLE : t3_rd;

  // data comes back a cycle after the request
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      src_a_q <= SRC_XP;
      src_b_q <= SRC_ZP;
    end else begin
      src_a_q <= cmd.src_a;
      src_b_q <= cmd.src_b;
    end
  end

  assign dout_a = pick_dout(src_a_q, xp_dout, zp_dout, t4_dout, t5_dout);
  assign dout_b = pick_dout(src_b_q, xp_dout, zp_dout, t4_dout, t5_dout);

  fp2_word_mem u_t4 (
    .clk  (clk),
    .rd   (t4_rd),
    .wr   (t4_wr),
    .dout (t4_dout)
  );

  fp2_word_mem u_t5 (
    .clk  (clk),
    .rd   (t5_rd),
    .wr   (t5_wr),
    .dout (t5_dout)
  );

  fp2_word_mem u_t2 (
    .clk  (clk),
    .rd   (t2_mem_rd),
    .wr   (t2_wr),
    .dout (t2_dout)
  );

  fp2_word_mem u_t3 (
    .clk  (clk),
    .rd   (t3_mem_rd),
    .wr   (t3_wr),
    .dout (t3_dout)
  );

endmodule

`default_nettype wire

//--- design/xadd_defs.svh
`ifndef XADD_DEFS_SVH
`define XADD_DEFS_SVH

// bits per digit
`define XADD_RADIX 16

// digits per Fp element, least significant first
`define XADD_DIGITS 4

// one half-select bit on top of the digit index
`define XADD_ADDR_W 3

// field modulus p, RADIX*DIGITS bits wide
`define XADD_PRIME 64'hffffffff00000001

`endif

//--- design/xadd_pkg.sv
`default_nettype none
`include "xadd_defs.svh"

package xadd_pkg;

  typedef logic [`XADD_RADIX-1:0] digit_t;

  // msb picks real/imag half, low bits pick the digit
  typedef logic [`XADD_ADDR_W-1:0] mem_addr_t;

  typedef struct packed {
    logic      en;
    mem_addr_t addr;
  } mem_rd_req_t;

  typedef struct packed {
    logic      en;
    mem_addr_t addr;
    digit_t    data;
  } mem_wr_req_t;

  typedef enum logic {
    OP_ADD,
    OP_SUB
  } addsub_op_e;

  typedef enum logic [1:0] {
    SRC_XP,
    SRC_ZP,
    SRC_T4,
    SRC_T5
  } operand_sel_e;

  typedef enum logic [1:0] {
    DST_T4,
    DST_T5,
    DST_T2,
    DST_T3
  } dest_sel_e;

  typedef struct packed {
    addsub_op_e   op;
    operand_sel_e src_a;
    operand_sel_e src_b;
    dest_sel_e    dst;
  } addsub_cmd_t;

endpackage

`default_nettype wire

//--- design/xadd_sequencer.sv
`default_nettype none

module xadd_sequencer (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start,
  output logic                  busy,
  output logic                  done,
  output xadd_pkg::addsub_cmd_t cmd,
  output logic                  unit_start,
  input  logic                  unit_done
);
  import xadd_pkg::*;

  localparam logic [1:0] LAST_STEP = 2'd3;

  typedef enum logic [1:0] {
    S_IDLE,
    S_ISSUE,
    S_WAIT
  } state_e;

  state_e     state;
  logic [1:0] step;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= S_IDLE;
      step  <= 2'd0;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        // start while running falls through here unseen
        S_IDLE: begin
          if (start) begin
            step  <= 2'd0;
            state <= S_ISSUE;
          end
        end
        S_ISSUE: begin
          state <= S_WAIT;
        end
        S_WAIT: begin
          if (unit_done) begin
            if (step == LAST_STEP) begin
              state <= S_IDLE;
              done  <= 1'b1;
            end else begin
              step  <= step + 2'd1;
              state <= S_ISSUE;
            end
          end
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  assign busy = (state != S_IDLE);
  assign unit_start = (state == S_ISSUE);

  // t4 = xp + zp, t5 = xp - zp, t2 = t4 + t5, t3 = t4 - t5
  always_comb begin
    case (step)
      2'd0:    cmd = '{op: OP_ADD, src_a: SRC_XP, src_b: SRC_ZP, dst: DST_T4};
      2'd1:    cmd = '{op: OP_SUB, src_a: SRC_XP, src_b: SRC_ZP, dst: DST_T5};
      2'd2:    cmd = '{op: OP_ADD, src_a: SRC_T4, src_b: SRC_T5, dst: DST_T2};
      default: cmd = '{op: OP_SUB, src_a: SRC_T4, src_b: SRC_T5, dst: DST_T3};
    endcase
  end

endmodule

`default_nettype wire

//--- design/xadd_top.sv
`default_nettype none

module xadd_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start,
  output logic                  busy,
  output logic                  done,
  output xadd_pkg::mem_rd_req_t xp_rd,
  output xadd_pkg::mem_rd_req_t zp_rd,
  input  xadd_pkg::digit_t      xp_dout,
  input  xadd_pkg::digit_t      zp_dout,
  input  xadd_pkg::mem_rd_req_t t2_rd,
  input  xadd_pkg::mem_rd_req_t t3_rd,
  output xadd_pkg::digit_t      t2_dout,
  output xadd_pkg::digit_t      t3_dout
);
  import xadd_pkg::*;

  addsub_cmd_t cmd;
  logic        unit_start;
  logic        unit_done;
  mem_rd_req_t rd_a;
  mem_rd_req_t rd_b;
  mem_wr_req_t wr;
  digit_t      dout_a;
  digit_t      dout_b;

  xadd_sequencer u_seq (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .busy       (busy),
    .done       (done),
    .cmd        (cmd),
    .unit_start (unit_start),
    .unit_done  (unit_done)
  );

  fp2_add_sub u_add_sub (
    .clk    (clk),
    .rst    (rst),
    .start  (unit_start),
    .op     (cmd.op),
    .rd_a   (rd_a),
    .rd_b   (rd_b),
    .dout_a (dout_a),
    .dout_b (dout_b),
    .wr     (wr),
    .done   (unit_done)
  );

  operand_router u_router (
    .clk     (clk),
    .rst     (rst),
    .cmd     (cmd),
    .busy    (busy),
    .rd_a    (rd_a),
    .rd_b    (rd_b),
    .wr      (wr),
    .dout_a  (dout_a),
    .dout_b  (dout_b),
    .xp_rd   (xp_rd),
    .zp_rd   (zp_rd),
    .xp_dout (xp_dout),
    .zp_dout (zp_dout),
    .t2_rd   (t2_rd),
    .t3_rd   (t3_rd),
    .t2_dout (t2_dout),
    .t3_dout (t3_dout)
  );

endmodule

`default_nettype wire

//--- filelist.f
+incdir+design
design/xadd_pkg.sv
design/fp2_word_mem.sv
design/fp2_add_sub.sv
design/operand_router.sv
design/xadd_sequencer.sv
design/xadd_top.sv
verification/xadd_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the xadd testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps --top-module xadd_tb \
  -f filelist.f --Mdir "$build_dir" -o xadd_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

"./$build_dir/xadd_sim" > "$log" 2>&1
run_status=$?
cat "$log"

if grep -q "Testbench failed" "$log"; then
  echo "simulation reported a failure, see $log"
  exit 1
fi

if [ $run_status -ne 0 ]; then
  echo "simulator exited with status $run_status"
  exit 1
fi

echo "simulation finished without failures"
exit 0

//--- verification/xadd_tb.sv
`default_nettype none
`include "xadd_defs.svh"

module xadd_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import xadd_pkg::*;

  localparam int RADIX = `XADD_RADIX;
  localparam int DIGITS = `XADD_DIGITS;
  localparam int ELEM_W = RADIX * DIGITS;
  localparam int NUM_TESTS = 3;
  localparam int WORDS_PER_TEST = 8;
  localparam int NUM_WORDS = NUM_TESTS * WORDS_PER_TEST;
  localparam int CYCLES_PER_TEST = 200;
  localparam int RUN_LIMIT = 150;
  localparam int RESET_CYCLES = 8;
  // start pulse during the run lands here
  localparam int EXTRA_START_AT = 20;

  logic        clk;
  logic        rst;
  logic        start;
  logic        busy;
  logic        done;
  mem_rd_req_t xp_rd;
  mem_rd_req_t zp_rd;
  digit_t      xp_dout;
  digit_t      zp_dout;
  mem_rd_req_t t2_rd;
  mem_rd_req_t t3_rd;
  digit_t      t2_dout;
  digit_t      t3_dout;

  logic [ELEM_W-1:0] vec [NUM_WORDS];
  digit_t            xp_mem [2*DIGITS];
  digit_t            zp_mem [2*DIGITS];
  mem_rd_req_t       xp_req_q;
  mem_rd_req_t       zp_req_q;
  logic              loaded;
  int                seed;
  int                ref_cycles;

  xadd_top uut (
    .clk     (clk),
    .rst     (rst),
    .start   (start),
    .busy    (busy),
    .done    (done),
    .xp_rd   (xp_rd),
    .zp_rd   (zp_rd),
    .xp_dout (xp_dout),
    .zp_dout (zp_dout),
    .t2_rd   (t2_rd),
    .t3_rd   (t3_rd),
    .t2_dout (t2_dout),
    .t3_dout (t3_dout)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  // outside XP/ZP memories, data back one cycle after the request
  always @(negedge clk) begin
    if (xp_req_q.en) begin
      xp_dout <= xp_mem[xp_req_q.addr];
    end
    if (zp_req_q.en) begin
      zp_dout <= zp_mem[zp_req_q.addr];
    end
    xp_req_q <= xp_rd;
    zp_req_q <= zp_rd;
  end

  function automatic logic [ELEM_W-1:0] fill_word(input int i);
    return {32'(i) ^ 32'h5a5a_a5a5, ~32'(i)};
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [ELEM_W-1:0] expected,
                             input logic [ELEM_W-1:0] actual);
    if (actual !== expected) begin
      fail_run($sformatf("** Error: %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  task automatic check_idle(input string phase);
    check_value({phase, " busy"}, '0, ELEM_W'(busy));
    check_value({phase, " done"}, '0, ELEM_W'(done));
    check_value({phase, " xp_rd.en"}, '0, ELEM_W'(xp_rd.en));
    check_value({phase, " zp_rd.en"}, '0, ELEM_W'(zp_rd.en));
  endtask

  task automatic idle_cycles(input int n, input string phase);
    repeat (n) begin
      @(negedge clk);
      check_idle(phase);
    end
  endtask

  task automatic load_operands(input int t);
    logic [ELEM_W-1:0] xr;
    logic [ELEM_W-1:0] xi;
    logic [ELEM_W-1:0] zr;
    logic [ELEM_W-1:0] zi;
    xr = vec[t*WORDS_PER_TEST + 0];
    xi = vec[t*WORDS_PER_TEST + 1];
    zr = vec[t*WORDS_PER_TEST + 2];
    zi = vec[t*WORDS_PER_TEST + 3];
    // real half low, imag half high, digits lsb first
    for (int d = 0; d < DIGITS; d++) begin
      xp_mem[d] = xr[d*RADIX +: RADIX];
      xp_mem[d+DIGITS] = xi[d*RADIX +: RADIX];
      zp_mem[d] = zr[d*RADIX +: RADIX];
      zp_mem[d+DIGITS] = zi[d*RADIX +: RADIX];
    end
  endtask

  task automatic run_once(input int t, input bit pulse_again);
    int    cycles;
    string name;
    cycles = 0;
    name = $sformatf("test %0d", t);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    while (done !== 1'b1) begin
      check_value({name, " busy while running"}, 1, ELEM_W'(busy));
      if (cycles == RUN_LIMIT) begin
        fail_run($sformatf("%s: done never came within %0d cycles", name, RUN_LIMIT));
      end
      start = pulse_again && (cycles == EXTRA_START_AT);
      cycles++;
      @(negedge clk);
    end
    start = 1'b0;
    // an ignored start leaves the fixed latency unchanged
    if (ref_cycles < 0) begin
      ref_cycles = cycles;
    end else begin
      check_value({name, " cycles to done"}, ELEM_W'(ref_cycles), ELEM_W'(cycles));
    end
    // busy drops together with done
    check_value({name, " busy with done"}, '0, ELEM_W'(busy));
    @(negedge clk);
    check_idle({name, " after done"});
  endtask

  task automatic read_results(input int t);
    logic [ELEM_W-1:0] t2_re;
    logic [ELEM_W-1:0] t2_im;
    logic [ELEM_W-1:0] t3_re;
    logic [ELEM_W-1:0] t3_im;
    string             name;
    name = $sformatf("test %0d", t);
    for (int i = 0; i < 2*DIGITS; i++) begin
      t2_rd = '{en: 1'b1, addr: mem_addr_t'(i)};
      t3_rd = '{en: 1'b1, addr: mem_addr_t'(i)};
      @(negedge clk);
      check_idle({name, " readback"});
      if (i < DIGITS) begin
        t2_re[i*RADIX +: RADIX] = t2_dout;
        t3_re[i*RADIX +: RADIX] = t3_dout;
      end else begin
        t2_im[(i-DIGITS)*RADIX +: RADIX] = t2_dout;
        t3_im[(i-DIGITS)*RADIX +: RADIX] = t3_dout;
      end
    end
    t2_rd = '0;
    t3_rd = '0;
    check_value({name, " t2 real"}, vec[t*WORDS_PER_TEST + 4], t2_re);
    check_value({name, " t2 imag"}, vec[t*WORDS_PER_TEST + 5], t2_im);
    check_value({name, " t3 real"}, vec[t*WORDS_PER_TEST + 6], t3_re);
    check_value({name, " t3 imag"}, vec[t*WORDS_PER_TEST + 7], t3_im);
  endtask

  initial begin
    int gap;
    rst = 1'b1;
    start = 1'b0;
    t2_rd = '0;
    t3_rd = '0;
    xp_dout <= '0;
    zp_dout <= '0;
    xp_req_q <= '0;
    zp_req_q <= '0;
    loaded = 1'b0;
    seed = 32'hff86;
    ref_cycles = -1;
    for (int i = 0; i < NUM_WORDS; i++) begin
      vec[i] = fill_word(i);
    end
    $readmemh("verification/xadd_testdata.hex", vec);
    if (vec[NUM_WORDS-1] == fill_word(NUM_WORDS-1)) begin
      fail_run("test data file is missing or holds too few values");
    end
    loaded = 1'b1;

    idle_cycles(RESET_CYCLES, "during reset");
    rst = 1'b0;
    idle_cycles(2, "after reset");

    for (int t = 0; t < NUM_TESTS; t++) begin
      load_operands(t);
      run_once(t, (t % 2) == 1);
      read_results(t);
      gap = $unsigned($random(seed)) % 8;
      idle_cycles(gap, $sformatf("gap after test %0d", t));
    end

    $display("Testbench passed");
    $finish;
  end

  // watchdog
  initial begin
    wait (loaded);
    repeat ((NUM_TESTS + 2) * CYCLES_PER_TEST) @(posedge clk);
    fail_run("the run timed out before all tests finished");
  end

endmodule

`default_nettype wire

//--- verification/xadd_testdata.hex
// per test, one value per line: xp real, xp imag, zp real, zp imag,
// then expected t2 real, t2 imag, t3 real, t3 imag (p = ffffffff00000001)
0000000000000000
ffffffff00000000
ffffffff00000000
0000000000000000
0000000000000000
fffffffeffffffff
fffffffeffffffff
0000000000000000
0123456789abcdef
1111111111111111
fedcba9876543210
2222222222222222
02468acf13579bde
2222222222222222
fdb97531eca8641f
4444444444444444
8000000000000000
0000000000000001
7fffffff80000001
ffffffff00000000
00000000ffffffff
0000000000000002
0000000000000001
fffffffeffffffff
